//--- files.f
+incdir+verilog
verilog/ooo_pkg.sv
verilog/exec_result_if.sv
verilog/cb_write_if.sv
verilog/commit_writeback.sv
verilog/completion_buffer.sv
verilog/ooo_commit_top.sv
sim/clk_gen.sv
sim/tb_ooo_commit.sv

//--- run.sh
#!/bin/sh
# build and run the commit pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps -f files.f \
  --top-module tb_ooo_commit -o sim_tb
out=$(./obj_dir/sim_tb || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Verification passed"

//--- sim/clk_gen.sv
// ==========================================================
// clock and reset for the testbench
// 4 ns period, nRST held low for the first 8 cycles and
// released on a falling edge, clear of the driving edge
// ==========================================================
`timescale 1ns/10ps

module clk_gen (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;  // 250 MHz
  end

  initial begin
    nRST = 1'b0;
    repeat (8) @(negedge CLK);
    nRST = 1'b1;            // mid-cycle release
  end

endmodule

//--- sim/tb_ooo_commit.sv
// ==========================================================
// directed tests for the commit pipeline top level
// inputs change 1 ns after the rising edge; retire and
// predictor pulses are collected on the falling edge
// expected retires come from a slot table plus an order queue
// ==========================================================
`timescale 1ns/10ps
`include "ooo_cfg.svh"

module tb_ooo_commit;
  import ooo_pkg::*;

  localparam int TIMEOUT = 50;  // cycles allowed per wait

  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
    word_t    epc;
    logic     wen;
    logic     exc;
  } retire_t;

  typedef struct packed {
    word_t addr;
    logic  taken;
    logic  misp;
  } pu_t;

  logic      CLK, nRST;
  logic      alloc_req, alloc_ack;
  reg_idx_t  alloc_rd;
  cb_index_t alloc_index;
  logic      res_valid, res_exception, res_jump, res_branch, res_taken, res_prediction;
  cb_index_t res_index;
  word_t     res_wdata, res_pc, res_jump_addr, res_br_addr;
  logic      retire_valid, retire_wen, retire_exception;
  reg_idx_t  retire_rd;
  word_t     retire_wdata, retire_epc;
  logic      pu_valid, pu_taken, pu_mispredict;
  word_t     pu_addr;

  retire_t     exp_slot [`OOO_CB_DEPTH];  // expected retire per slot
  cb_index_t   order_q [$];               // outstanding slots in age order
  retire_t     got_q [$];
  pu_t         pu_q [$];
  logic [31:0] rng_state = 32'h0e37825d;

  clk_gen u_clk (.CLK(CLK), .nRST(nRST));
  ooo_commit_top i_dut (.*);

  // pulses are stable mid-cycle
  always @(negedge CLK) begin
    if (retire_valid)
      got_q.push_back({retire_rd, retire_wdata, retire_epc, retire_wen, retire_exception});
    if (pu_valid)
      pu_q.push_back({pu_addr, pu_taken, pu_mispredict});
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;  // xorshift32
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic cmp_index(input string name, input cb_index_t got, input cb_index_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic cmp_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic cmp_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      stop_on_error($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic cmp_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // one cycle of a bounded wait that ends 1 ns after the edge
  task automatic wait_cycle(inout int n, input string what);
    @(posedge CLK);
    #1;
    n++;
    if (n > TIMEOUT)
      stop_on_error({"timeout waiting for ", what});
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (alloc_ack !== level)
      wait_cycle(n, "alloc_ack");
  endtask

  // record the slot and close the handshake once ack is high
  task automatic finish_alloc(output cb_index_t idx);
    idx = alloc_index;
    exp_slot[idx].rd = alloc_rd;
    order_q.push_back(idx);
    alloc_req = 1'b0;
    wait_ack(1'b0);  // next request only after ack falls
  endtask

  task automatic do_alloc(output cb_index_t idx);
    alloc_rd  = reg_idx_t'(next_rand());
    alloc_req = 1'b1;
    wait_ack(1'b1);
    finish_alloc(idx);
  endtask

  task automatic send_result(input cb_index_t idx, input word_t data, input word_t pc,
                             input logic exc, input logic jump, input word_t jaddr,
                             input logic br, input logic taken, input logic pred,
                             input word_t baddr);
    logic e;
    // misaligned target only counts when control goes there
    e = exc | (jump & (jaddr[1:0] != 2'b00)) | (br & taken & (baddr[1:0] != 2'b00));
    exp_slot[idx].exc  = e;
    exp_slot[idx].wen  = !(e | br);
    exp_slot[idx].data = e ? pc : (jump ? pc + 32'd4 : data);
    res_valid      = 1'b1;
    res_index      = idx;
    res_wdata      = data;
    res_pc         = pc;
    res_exception  = exc;
    res_jump       = jump;
    res_jump_addr  = jaddr;
    res_branch     = br;
    res_taken      = taken;
    res_prediction = pred;
    res_br_addr    = baddr;
    @(posedge CLK);
    #1;
    res_valid = 1'b0;  // single-cycle pulse
  endtask

  task automatic send_alu(input cb_index_t idx);
    send_result(idx, next_rand(), next_rand() & ~32'h3, 1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic check_retire();
    retire_t   got;
    cb_index_t idx;
    int        n;
    n = 0;
    while (got_q.size() == 0)
      wait_cycle(n, "retire_valid");
    if (order_q.size() == 0)
      stop_on_error("retire seen with no entry outstanding");
    got = got_q.pop_front();
    idx = order_q.pop_front();  // program order
    cmp_reg("retire_rd", got.rd, exp_slot[idx].rd);
    cmp_bit("retire_exception", got.exc, exp_slot[idx].exc);
    cmp_bit("retire_wen", got.wen, exp_slot[idx].wen);
    if (exp_slot[idx].exc) begin
      cmp_word("retire_epc", got.epc, exp_slot[idx].data);
      order_q.delete();  // younger entries are flushed
    end else begin
      cmp_word("retire_wdata", got.data, exp_slot[idx].data);
    end
  endtask

  task automatic check_pu(input word_t addr, input logic taken, input logic pred);
    pu_t got;
    int  n;
    n = 0;
    while (pu_q.size() == 0)
      wait_cycle(n, "pu_valid");
    got = pu_q.pop_front();
    cmp_word("pu_addr", got.addr, addr);
    cmp_bit("pu_taken", got.taken, taken);
    cmp_bit("pu_mispredict", got.misp, pred ^ taken);
  endtask

  task automatic reset_state();
    cb_index_t idx;
    cmp_bit("alloc_ack", alloc_ack, 1'b0);
    cmp_bit("retire_valid", retire_valid, 1'b0);
    cmp_bit("retire_wen", retire_wen, 1'b0);
    cmp_bit("retire_exception", retire_exception, 1'b0);
    cmp_bit("pu_valid", pu_valid, 1'b0);
    do_alloc(idx);
    cmp_index("alloc_index", idx, '0);
    send_alu(idx);
    check_retire();
  endtask

  task automatic in_order_retire();
    cb_index_t ids [4];
    for (int i = 0; i < 4; i++)
      do_alloc(ids[i]);
    send_alu(ids[3]);  // youngest first
    send_alu(ids[1]);
    send_alu(ids[0]);
    send_alu(ids[2]);
    repeat (4) check_retire();
  endtask

  task automatic jump_data();
    cb_index_t a, b, c;
    do_alloc(a);
    do_alloc(b);
    send_result(a, next_rand(), 32'h0000_2000, 1'b0, 1'b1, 32'h0000_3004,
                1'b0, 1'b0, 1'b0, '0);
    send_result(b, next_rand(), 32'h0000_2004, 1'b0, 1'b1, 32'h0000_3006,
                1'b0, 1'b0, 1'b0, '0);  // target off by two
    check_retire();
    check_retire();
    do_alloc(c);
    cmp_index("alloc_index", c, cb_index_t'(b + 1));
    send_alu(c);
    check_retire();
  endtask

  task automatic branch_update();
    cb_index_t a, b, c;
    do_alloc(a);
    do_alloc(b);
    send_result(a, next_rand(), 32'h0000_4000, 1'b0, 1'b0, '0,
                1'b1, 1'b1, 1'b0, 32'h0000_4010);  // taken but guessed not taken
    check_pu(32'h0000_4010, 1'b1, 1'b0);
    send_result(b, next_rand(), 32'h0000_4004, 1'b0, 1'b0, '0,
                1'b1, 1'b0, 1'b0, 32'h0000_4022);  // not taken and guessed right
    check_pu(32'h0000_4022, 1'b0, 1'b0);
    check_retire();
    check_retire();
    do_alloc(c);
    send_result(c, next_rand(), 32'h0000_4008, 1'b0, 1'b0, '0,
                1'b1, 1'b1, 1'b1, 32'h0000_4012);  // taken to a misaligned target
    check_pu(32'h0000_4012, 1'b1, 1'b1);
    check_retire();
  endtask

  task automatic exception_flush();
    cb_index_t ids [3];
    cb_index_t nxt;
    for (int i = 0; i < 3; i++)
      do_alloc(ids[i]);
    send_alu(ids[1]);  // younger ones done before the fault
    send_alu(ids[2]);
    send_result(ids[0], next_rand(), 32'h0000_5000, 1'b1, 1'b0, '0,
                1'b0, 1'b0, 1'b0, '0);
    check_retire();
    repeat (16) @(posedge CLK);
    #1;
    if (got_q.size() != 0)
      stop_on_error("a flushed entry retired after the exception");
    do_alloc(nxt);
    cmp_index("alloc_index", nxt, cb_index_t'(ids[0] + 1));
    send_alu(nxt);
    check_retire();
  endtask

  task automatic full_buffer();
    cb_index_t ids [`OOO_CB_DEPTH];
    cb_index_t idx;
    for (int i = 0; i < `OOO_CB_DEPTH; i++)
      do_alloc(ids[i]);
    alloc_rd  = reg_idx_t'(next_rand());
    alloc_req = 1'b1;
    repeat (12) begin  // ack must stay withheld
      @(posedge CLK);
      #1;
      cmp_bit("alloc_ack", alloc_ack, 1'b0);
    end
    send_alu(ids[0]);
    wait_ack(1'b1);
    check_retire();    // head retires before the slot is reused
    finish_alloc(idx);
    cmp_index("alloc_index", idx, ids[0]);
  endtask

  initial begin
    int n;
    {alloc_req, res_valid, res_exception, res_jump, res_branch, res_taken} = '0;
    res_prediction = 1'b0;
    {alloc_rd, res_index, res_wdata, res_pc, res_jump_addr, res_br_addr} = '0;
    n = 0;
    while (nRST !== 1'b1)
      wait_cycle(n, "reset release");
    reset_state();
    in_order_retire();
    jump_data();
    branch_update();
    exception_flush();
    full_buffer();
    if (pu_q.size() != 0) begin
      stop_on_error("predictor update seen for a non-branch result");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

//--- verilog/cb_write_if.sv
// ==========================================================
// formatted completion update, writeback to buffer
// ready pulses one cycle per finished result
// ==========================================================
`timescale 1ns/10ps

interface cb_write_if;
  import ooo_pkg::*;

  logic      ready;     // entry done this cycle
  cb_index_t index;
  word_t     wdata;     // result, pc+4 or epc
  logic      wen;       // low for branches and exceptions
  logic      exception;

  modport writeback (
    output ready, index, wdata, wen, exception
  );

  modport buffer (
    input ready, index, wdata, wen, exception
  );

endinterface

//--- verilog/commit_writeback.sv
// ==========================================================
// one registered stage between execute and the buffer
// accepts a result every cycle, update appears next cycle
// only word alignment is checked on jump/branch targets
// predictor update pulses once per branch result
// ==========================================================
`timescale 1ns/10ps

module commit_writeback (
  input  logic                CLK,
  input  logic                nRST,
  exec_result_if.writeback    res,
  cb_write_if.writeback       cbw,
  output logic                pu_valid,
  output logic                pu_taken,
  output logic                pu_mispredict,
  output ooo_pkg::word_t      pu_addr
);
  import ooo_pkg::*;

  logic  jaddr_mal;  // jump target not word aligned
  logic  braddr_mal; // taken branch target not word aligned
  logic  wb_exc;
  word_t wb_data;
  logic  wb_wen;

  // misaligned targets only matter when control actually moves there
  assign jaddr_mal  = res.jump & (res.jump_addr[1:0] != 2'b00);
  assign braddr_mal = res.branch & res.taken & (res.br_addr[1:0] != 2'b00);
  assign wb_exc     = res.exception | jaddr_mal | braddr_mal;

  always_comb begin
    if (wb_exc)
      wb_data = res.pc;                 // epc rides in the data field
    else if (res.jump)
      wb_data = res.pc + word_t'(4);    // link value
    else
      wb_data = res.wdata;
  end

  assign wb_wen = ~(wb_exc | res.branch); // branches never write rd

  // pulses
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cbw.ready <= 1'b0;
      pu_valid  <= 1'b0;
    end else begin
      cbw.ready <= res.valid;
      pu_valid  <= res.valid & res.branch;
    end
  end

  // payload, qualified by the pulses above
  always_ff @(posedge CLK) begin
    cbw.index     <= res.index;
    cbw.wdata     <= wb_data;
    cbw.wen       <= wb_wen;
    cbw.exception <= wb_exc;
    pu_addr       <= res.br_addr;
    pu_taken      <= res.taken;
    pu_mispredict <= res.prediction ^ res.taken; // guess vs outcome
  end

endmodule

//--- verilog/completion_buffer.sv
// ==========================================================
// circular completion buffer, retires in program order
// slots handed out over a four-phase req/ack; ack withheld
// while full, one retire per cycle at most
// an excepting entry flushes everything younger, head and
// tail restart at the exception slot plus one
// ==========================================================
`timescale 1ns/10ps
`include "ooo_cfg.svh"

module completion_buffer (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                alloc_req,
  input  ooo_pkg::reg_idx_t   alloc_rd,
  output logic                alloc_ack,
  output ooo_pkg::cb_index_t  alloc_index,
  cb_write_if.buffer          cbw,
  output logic                retire_valid,
  output logic                retire_wen,
  output logic                retire_exception,
  output ooo_pkg::reg_idx_t   retire_rd,
  output ooo_pkg::word_t      retire_wdata,
  output ooo_pkg::word_t      retire_epc
);
  import ooo_pkg::*;

  localparam int DEPTH = `OOO_CB_DEPTH;
  localparam int CNT_W = $clog2(DEPTH) + 1; // holds 0..DEPTH

  // entry storage
  reg_idx_t         rd_q   [DEPTH];
  word_t            data_q [DEPTH];
  logic             wen_q  [DEPTH];
  logic             exc_q  [DEPTH];
  logic [DEPTH-1:0] done_q;          // result has arrived

  cb_index_t        head;            // oldest entry
  cb_index_t        tail;            // next slot to hand out
  logic [CNT_W-1:0] count;
  alloc_state_t     state;

  logic  full;
  logic  retire_go;
  logic  flush;
  logic  alloc_go;
  word_t ret_data;

  assign full      = (count == CNT_W'(DEPTH));
  assign retire_go = done_q[head] && (count != '0);
  assign flush     = retire_go && exc_q[head];    // exception at head
  // no new slot in the flush cycle, tail is about to move
  assign alloc_go  = (state == ALLOC_IDLE) && alloc_req && !full && !flush;

  // epc and result share the data field
  assign retire_wdata = ret_data;
  assign retire_epc   = ret_data;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state            <= ALLOC_IDLE;
      alloc_ack        <= 1'b0;
      alloc_index      <= '0;
      head             <= '0;
      tail             <= '0;
      count            <= '0;
      done_q           <= '0;
      retire_valid     <= 1'b0;
      retire_wen       <= 1'b0;
      retire_exception <= 1'b0;
    end else begin
      retire_valid     <= retire_go;
      retire_wen       <= retire_go & wen_q[head];
      retire_exception <= flush;

      case (state)
        ALLOC_IDLE: begin
          if (alloc_go) begin
            alloc_ack   <= 1'b1;
            alloc_index <= tail;  // held while ack is high
            state       <= ALLOC_ACK;
          end
        end
        ALLOC_ACK, ALLOC_WAIT_LOW: begin
          if (!alloc_req) begin   // producer let go, drop ack
            alloc_ack <= 1'b0;
            state     <= ALLOC_IDLE;
          end else begin
            state <= ALLOC_WAIT_LOW;
          end
        end
        default: begin
          alloc_ack <= 1'b0;
          state     <= ALLOC_IDLE;
        end
      endcase

      // done bits, set before clear so a flush wins
      if (cbw.ready)
        done_q[cbw.index] <= 1'b1;
      if (retire_go)
        done_q[head] <= 1'b0;

      if (flush) begin
        head   <= head + cb_index_t'(1);
        tail   <= head + cb_index_t'(1);  // next alloc gets exc slot + 1
        count  <= '0;
        done_q <= '0;                     // drop younger results
      end else begin
        if (retire_go)
          head <= head + cb_index_t'(1);
        if (alloc_go)
          tail <= tail + cb_index_t'(1);
        count <= count + CNT_W'(alloc_go) - CNT_W'(retire_go);
      end
    end
  end

  // payload, only read behind done_q / retire_valid
  always_ff @(posedge CLK) begin
    if (alloc_go)
      rd_q[tail] <= alloc_rd;        // rd captured at request time
    if (cbw.ready) begin
      data_q[cbw.index] <= cbw.wdata;
      wen_q[cbw.index]  <= cbw.wen;
      exc_q[cbw.index]  <= cbw.exception;
    end
    if (retire_go) begin
      retire_rd <= rd_q[head];
      ret_data  <= data_q[head];
    end
  end

endmodule

//--- verilog/exec_result_if.sv
// ==========================================================
// one execute result heading into writeback
// valid is a single-cycle pulse, no back-pressure
// each slot index completes at most once
// ==========================================================
`timescale 1ns/10ps

interface exec_result_if;
  import ooo_pkg::*;

  logic      valid;      // one-cycle pulse
  cb_index_t index;      // slot being completed
  word_t     wdata;      // unit result
  word_t     pc;
  logic      exception;  // raised by the unit itself

  logic      jump;
  word_t     jump_addr;  // resolved jump target

  logic      branch;
  logic      taken;
  logic      prediction; // what the front end guessed
  word_t     br_addr;    // resolved branch target

  // execute side drives
  modport exec (
    output valid, index, wdata, pc, exception,
    output jump, jump_addr,
    output branch, taken, prediction, br_addr
  );

  // writeback side samples
  modport writeback (
    input valid, index, wdata, pc, exception,
    input jump, jump_addr,
    input branch, taken, prediction, br_addr
  );

endinterface

//--- verilog/ooo_cfg.svh
// ==========================================================
// build-time sizing for the commit end of the pipeline
// OOO_CB_DEPTH must be a power of two, since the slot
// pointers wrap by overflow
// no module code here, defines only
// ==========================================================
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// data and address width
`define OOO_XLEN 32

// completion buffer entries, power of two
`define OOO_CB_DEPTH 8

// architectural registers
`define OOO_NREG 32

`endif

//--- verilog/ooo_commit_top.sv
// ==========================================================
// commit end top level, plain ports only
// res_valid is a one-cycle pulse, no stall path back
// into execute; only alloc_ack applies back-pressure
// ==========================================================
`timescale 1ns/10ps

module ooo_commit_top (
  input  logic                CLK,
  input  logic                nRST,
  // slot allocation
  input  logic                alloc_req,
  input  ooo_pkg::reg_idx_t   alloc_rd,
  output logic                alloc_ack,
  output ooo_pkg::cb_index_t  alloc_index,
  // execute result
  input  logic                res_valid,
  input  ooo_pkg::cb_index_t  res_index,
  input  ooo_pkg::word_t      res_wdata,
  input  ooo_pkg::word_t      res_pc,
  input  logic                res_exception,
  input  logic                res_jump,
  input  ooo_pkg::word_t      res_jump_addr,
  input  logic                res_branch,
  input  logic                res_taken,
  input  logic                res_prediction,
  input  ooo_pkg::word_t      res_br_addr,
  // architectural retire
  output logic                retire_valid,
  output logic                retire_wen,
  output logic                retire_exception,
  output ooo_pkg::reg_idx_t   retire_rd,
  output ooo_pkg::word_t      retire_wdata,
  output ooo_pkg::word_t      retire_epc,
  // predictor update
  output logic                pu_valid,
  output logic                pu_taken,
  output logic                pu_mispredict,
  output ooo_pkg::word_t      pu_addr
);

  exec_result_if res_if ();
  cb_write_if    cbw_if ();

  // plain ports onto the result bundle
  assign res_if.valid      = res_valid;
  assign res_if.index      = res_index;
  assign res_if.wdata      = res_wdata;
  assign res_if.pc         = res_pc;
  assign res_if.exception  = res_exception;
  assign res_if.jump       = res_jump;
  assign res_if.jump_addr  = res_jump_addr;
  assign res_if.branch     = res_branch;
  assign res_if.taken      = res_taken;
  assign res_if.prediction = res_prediction;
  assign res_if.br_addr    = res_br_addr;

  commit_writeback u_writeback (
    .CLK           (CLK),
    .nRST          (nRST),
    .res           (res_if.writeback),
    .cbw           (cbw_if.writeback),
    .pu_valid      (pu_valid),
    .pu_taken      (pu_taken),
    .pu_mispredict (pu_mispredict),
    .pu_addr       (pu_addr)
  );

  completion_buffer u_buffer (
    .CLK              (CLK),
    .nRST             (nRST),
    .alloc_req        (alloc_req),
    .alloc_rd         (alloc_rd),
    .alloc_ack        (alloc_ack),
    .alloc_index      (alloc_index),
    .cbw              (cbw_if.buffer),
    .retire_valid     (retire_valid),
    .retire_wen       (retire_wen),
    .retire_exception (retire_exception),
    .retire_rd        (retire_rd),
    .retire_wdata     (retire_wdata),
    .retire_epc       (retire_epc)
  );

endmodule

//--- verilog/ooo_pkg.sv
// ==========================================================
// shared types for the commit pipeline
// widths come from ooo_cfg.svh; a change there resizes
// every slot index, register number and data word
// ==========================================================
`include "ooo_cfg.svh"

package ooo_pkg;

  // one data or address word
  typedef logic [`OOO_XLEN-1:0] word_t;

  // completion buffer slot, wraps at OOO_CB_DEPTH
  typedef logic [$clog2(`OOO_CB_DEPTH)-1:0] cb_index_t;

  // architectural destination register number
  typedef logic [$clog2(`OOO_NREG)-1:0] reg_idx_t;

  // four-phase allocation handshake
  typedef enum logic [1:0] {
    ALLOC_IDLE     = 2'd0, // waiting for a request
    ALLOC_ACK      = 2'd1, // ack just raised
    ALLOC_WAIT_LOW = 2'd2  // ack held until req drops
  } alloc_state_t;

endpackage
